/* design/nocArb_params.svh */
`ifndef NOCARB_PARAMS_SVH
`define NOCARB_PARAMS_SVH

////////////////////
// Port count
////////////////////

// Local, North, East, West and South.
`define NUM_PORTS 5

////////////////////
// Flit layout
////////////////////

`define FLIT_W    16
`define TYPE_MSB  15
`define TYPE_LSB  13

// Length field of a head flit, also the width of a timer budget.
`define LEN_W     12

`endif

/* design/nocArbPkg.sv */
`default_nettype none

`include "nocArb_params.svh"

package nocArbPkg;

  // Carried in bits TYPE_MSB down to TYPE_LSB of every flit.
  typedef enum logic [`TYPE_MSB-`TYPE_LSB:0] {
    HEAD = 3'd1,
    BODY = 3'd2,
    TAIL = 3'd3
  } flitType_e;

  // One-hot, bit p+1 marks port p as the grant holder.
  typedef enum logic [`NUM_PORTS:0] {
    IDLE = 6'b000001,
    GL   = 6'b000010,
    GN   = 6'b000100,
    GE   = 6'b001000,
    GW   = 6'b010000,
    GS   = 6'b100000
  } grantState_e;

  // Indexed Local 0, North 1, East 2, West 3, South 4.
  typedef logic [`NUM_PORTS-1:0] portVec_t;

endpackage

`default_nettype wire

/* design/portTimer.sv */
`default_nettype none

`include "nocArb_params.svh"

module portTimer (
  input  logic              clk,
  input  logic              rst,
  input  logic              run,
  input  logic              load,
  input  logic              step,
  input  logic [`LEN_W-1:0] length,
  output logic              timesUp
);

  logic [`LEN_W-1:0] budget;
  logic [`LEN_W-1:0] count;

  // Full budget until the first header sets one.
  always_ff @(posedge clk)
  begin
    if (rst)
      budget <= '1;
    else if (load)
      budget <= length;
  end

  // Counts forwarded flits, not cycles.
  always_ff @(posedge clk)
  begin
    if (rst || !run)
      count <= '0;
    else if (step)
      count <= count + 1'b1;
  end

  assign timesUp = (count >= budget);

endmodule

`default_nettype wire

/* design/flitIngress.sv */
`default_nettype none

`include "nocArb_params.svh"

module flitIngress (
  input  logic               clk,
  input  logic               rst,
  input  logic               inReq,
  input  logic [`FLIT_W-1:0] inFlit,
  output logic               inAck,
  input  logic               take,
  output logic               pending,
  output logic [`FLIT_W-1:0] heldFlit
);

  typedef enum logic [1:0] {
    EMPTY,
    FULL,
    ACKING
  } ingState_e;

  ingState_e state;
  ingState_e nextState;

  always_comb
  begin
    nextState = state;
    case (state)
      EMPTY:
        if (inReq)
          nextState = FULL;
      FULL:
        if (take)
          nextState = ACKING;
      // Ack is held until the sender drops req.
      ACKING:
        if (!inReq)
          nextState = EMPTY;
      default:
        nextState = EMPTY;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= EMPTY;
    else
      state <= nextState;
  end

  // Data is stable while req is high.
  always_ff @(posedge clk)
  begin
    if (state == EMPTY && inReq)
      heldFlit <= inFlit;
  end

  assign pending = (state == FULL);
  assign inAck   = (state == ACKING);

endmodule

`default_nettype wire

/* design/grantArbiter.sv */
`default_nettype none

`include "nocArb_params.svh"

module grantArbiter (
  input  logic                   clk,
  input  logic                   rst,
  input  nocArbPkg::portVec_t    pending,
  input  logic [`FLIT_W-1:0]     heldFlit [`NUM_PORTS],
  input  nocArbPkg::portVec_t    take,
  output nocArbPkg::grantState_e grant
);

  nocArbPkg::portVec_t    run;
  nocArbPkg::portVec_t    load;
  nocArbPkg::portVec_t    timesUp;
  nocArbPkg::grantState_e nextGrant;
  logic [2:0]             curPort;
  logic                   keep;

  // First pending port at or after start, wrapping past South.
  function automatic nocArbPkg::grantState_e firstPending(
    input nocArbPkg::portVec_t req,
    input int unsigned         start
  );
    nocArbPkg::grantState_e pick;
    int unsigned            idx;
    pick = nocArbPkg::IDLE;
    // Walk backwards so the closest port is picked last.
    for (int i = `NUM_PORTS - 1; i >= 0; i--)
    begin
      idx = start + i;
      if (idx >= `NUM_PORTS)
        idx = idx - `NUM_PORTS;
      if (req[idx])
        pick = nocArbPkg::grantState_e'(6'b000010 << idx);
    end
    return pick;
  endfunction

  ////////////////////
  // Per-port timers
  ////////////////////

  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : gTimer
    assign run[p]  = grant[p + 1];
    assign load[p] = take[p] &&
      (nocArbPkg::flitType_e'(heldFlit[p][`TYPE_MSB:`TYPE_LSB]) == nocArbPkg::HEAD);

    portTimer u_portTimer (
      .clk     (clk),
      .rst     (rst),
      .run     (run[p]),
      .load    (load[p]),
      .step    (take[p]),
      .length  (heldFlit[p][`LEN_W-1:0]),
      .timesUp (timesUp[p])
    );
  end

  ////////////////////
  // Grant FSM
  ////////////////////

  always_comb
  begin
    case (grant)
      nocArbPkg::GL:
        curPort = 3'd0;
      nocArbPkg::GN:
        curPort = 3'd1;
      nocArbPkg::GE:
        curPort = 3'd2;
      nocArbPkg::GW:
        curPort = 3'd3;
      nocArbPkg::GS:
        curPort = 3'd4;
      default:
        curPort = 3'd0;
    endcase
  end

  // The holder stays until it runs dry or spends its budget.
  assign keep = pending[curPort] && !timesUp[curPort];

  always_comb
  begin
    if (grant == nocArbPkg::IDLE)
      nextGrant = firstPending(pending, 0);
    else if (keep)
      nextGrant = grant;
    else
      nextGrant = firstPending(pending, curPort + 1);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= nocArbPkg::IDLE;
    else
      grant <= nextGrant;
  end

endmodule

`default_nettype wire

/* design/flitForward.sv */
`default_nettype none

`include "nocArb_params.svh"

module flitForward (
  input  logic                   clk,
  input  logic                   rst,
  input  nocArbPkg::grantState_e grant,
  input  nocArbPkg::portVec_t    pending,
  input  logic [`FLIT_W-1:0]     heldFlit [`NUM_PORTS],
  output nocArbPkg::portVec_t    take,
  output logic                   outReq,
  output logic [`FLIT_W-1:0]     outFlit,
  input  logic                   outAck
);

  typedef enum logic [1:0] {
    READY,
    SEND,
    DRAIN
  } fwdState_e;

  fwdState_e           state;
  nocArbPkg::portVec_t granted;
  logic [`FLIT_W-1:0]  selFlit;
  logic                loadFlit;

  assign granted  = grant[`NUM_PORTS:1];
  assign take     = (state == READY) ? (granted & pending) : '0;
  assign loadFlit = |take;

  // Grant is one-hot so an OR of the masked flits picks one.
  always_comb
  begin
    selFlit = '0;
    for (int p = 0; p < `NUM_PORTS; p++)
      if (granted[p])
        selFlit = selFlit | heldFlit[p];
  end

  always_ff @(posedge clk)
  begin
    if (loadFlit)
      outFlit <= selFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= READY;
    else
      case (state)
        READY:
          if (loadFlit)
            state <= SEND;
        SEND:
          if (outAck)
            state <= DRAIN;
        DRAIN:
          if (!outAck)
            state <= READY;
        default:
          state <= READY;
      endcase
  end

  assign outReq = (state == SEND);

endmodule

`default_nettype wire

/* design/nocArbTop.sv */
`default_nettype none

`include "nocArb_params.svh"

module nocArbTop (
  input  logic                clk,
  input  logic                rst,
  input  nocArbPkg::portVec_t inReq,
  input  logic [`FLIT_W-1:0]  inFlit [`NUM_PORTS],
  output nocArbPkg::portVec_t inAck,
  output logic                outReq,
  output logic [`FLIT_W-1:0]  outFlit,
  input  logic                outAck
);

  nocArbPkg::portVec_t    pending;
  nocArbPkg::portVec_t    take;
  nocArbPkg::grantState_e grant;
  logic [`FLIT_W-1:0]     heldFlit [`NUM_PORTS];

  ////////////////////
  // Ingress stage
  ////////////////////

  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : gIngress
    flitIngress u_flitIngress (
      .clk      (clk),
      .rst      (rst),
      .inReq    (inReq[p]),
      .inFlit   (inFlit[p]),
      .inAck    (inAck[p]),
      .take     (take[p]),
      .pending  (pending[p]),
      .heldFlit (heldFlit[p])
    );
  end

  ////////////////////
  // Arbitration and output
  ////////////////////

  grantArbiter u_grantArbiter (
    .clk      (clk),
    .rst      (rst),
    .pending  (pending),
    .heldFlit (heldFlit),
    .take     (take),
    .grant    (grant)
  );

  flitForward u_flitForward (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .pending  (pending),
    .heldFlit (heldFlit),
    .take     (take),
    .outReq   (outReq),
    .outFlit  (outFlit),
    .outAck   (outAck)
  );

endmodule

`default_nettype wire

/* tests/nocArb_checker.sv */
`default_nettype none

`include "nocArb_params.svh"

module nocArb_checker (
  input logic                   clk,
  input logic                   rst,
  input nocArbPkg::portVec_t    inReq,
  input nocArbPkg::portVec_t    inAck,
  input nocArbPkg::portVec_t    take,
  input nocArbPkg::grantState_e grant,
  input logic                   outReq,
  input logic [`FLIT_W-1:0]     outFlit
);

  timeunit 1ns;
  timeprecision 1ps;

  nocArbPkg::portVec_t granted;

  assign granted = grant[`NUM_PORTS:1];

  // Output data holds for the whole request phase.
  assert property (@(posedge clk) disable iff (rst) outReq && $past(outReq) |-> $stable(outFlit))
    else $error("outFlit changed while outReq was high");

  assert property (@(posedge clk) disable iff (rst) $onehot0(take))
    else $error("take selects more than one port");

  assert property (@(posedge clk) disable iff (rst) (take & ~granted) == '0)
    else $error("take selects a port that does not hold the grant");

  // An ack may only answer a live request.
  assert property (@(posedge clk) disable iff (rst) ((inAck & ~$past(inAck)) & ~inReq) == '0)
    else $error("inAck rose on a link without inReq");

endmodule

bind nocArbTop nocArb_checker u_nocArb_checker (
  .clk     (clk),
  .rst     (rst),
  .inReq   (inReq),
  .inAck   (inAck),
  .take    (take),
  .grant   (grant),
  .outReq  (outReq),
  .outFlit (outFlit)
);

`default_nettype wire

/* tests/nocArbTb.sv */
`default_nettype none

`include "nocArb_params.svh"

module nocArbTb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int maxFlits   = 8;
  localparam int maxLog     = 32;
  // Flits sent over all tests, and a generous bound per flit.
  localparam int totalFlits = 53;
  localparam int flitBound  = 40;
  localparam int cycleLimit = totalFlits * flitBound + 100;

  logic                clk;
  logic                rst;
  nocArbPkg::portVec_t inReq;
  logic [`FLIT_W-1:0]  inFlit [`NUM_PORTS];
  nocArbPkg::portVec_t inAck;
  logic                outReq;
  logic [`FLIT_W-1:0]  outFlit;
  logic                outAck;

  logic [`FLIT_W-1:0] txFlit [`NUM_PORTS][maxFlits];
  int                 txCount [`NUM_PORTS];
  logic [`FLIT_W-1:0] rxFlit [maxLog];
  int                 rxSrc [maxLog];
  int                 rxCount;
  int                 errorCount;
  int                 checkCount;
  int                 cycleCount = 0;
  int                 ackDelayMax;
  integer             seed;

  nocArbTop u_nocArbTop (
    .clk     (clk),
    .rst     (rst),
    .inReq   (inReq),
    .inFlit  (inFlit),
    .inAck   (inAck),
    .outReq  (outReq),
    .outFlit (outFlit),
    .outAck  (outAck)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #10 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("tests failed");
      $finish;
    end
  end

  ////////////////////
  // Flits and checks
  ////////////////////

  function automatic logic [`FLIT_W-1:0] headFlit(input int len);
    headFlit = {nocArbPkg::HEAD, 1'b0, len[`LEN_W-1:0]};
  endfunction

  // Body and tail flits carry the source port and a sequence number.
  function automatic logic [`FLIT_W-1:0] dataFlit(input nocArbPkg::flitType_e kind,
                                                  input int src, input int seq);
    dataFlit = {kind, src[2:0], seq[9:0]};
  endfunction

  task automatic checkValue(input logic [31:0] expected, input logic [31:0] actual,
                            input string what);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("ERR %0t: %s, expected %0h, got %0h", $time, what, expected, actual);
    end
  endtask

  task automatic clearStimulus();
    for (int p = 0; p < `NUM_PORTS; p++)
      txCount[p] = 0;
    rxCount = 0;
  endtask

  task automatic addFlit(input int port, input logic [`FLIT_W-1:0] flit);
    txFlit[port][txCount[port]] = flit;
    txCount[port] = txCount[port] + 1;
  endtask

  task automatic addPacket(input int port, input int len, input int flits);
    addFlit(port, headFlit(len));
    for (int i = 1; i < flits - 1; i++)
      addFlit(port, dataFlit(nocArbPkg::BODY, port, i));
    if (flits > 1)
      addFlit(port, dataFlit(nocArbPkg::TAIL, port, flits - 1));
  endtask

  // Four-phase sender for one input link.
  task automatic sendPort(input int port);
    for (int i = 0; i < txCount[port]; i++)
    begin
      @(posedge clk);
      inFlit[port] <= txFlit[port][i];
      inReq[port]  <= 1'b1;
      do
        @(posedge clk);
      while (!inAck[port]);
      inReq[port] <= 1'b0;
      do
        @(posedge clk);
      while (inAck[port]);
    end
  endtask

  task automatic runPorts();
    int total;
    total = 0;
    for (int p = 0; p < `NUM_PORTS; p++)
      total += txCount[p];
    fork
      sendPort(0);
      sendPort(1);
      sendPort(2);
      sendPort(3);
      sendPort(4);
    join
    while (rxCount < total)
      @(posedge clk);
    while (outReq || outAck)
      @(posedge clk);
    repeat (4) @(posedge clk);
    checkValue(total, rxCount, "output flit count");
  endtask

  // Each port's flits come out unchanged and in the order they were sent.
  task automatic checkPortOrder();
    int seen [`NUM_PORTS];
    int src;
    for (int p = 0; p < `NUM_PORTS; p++)
      seen[p] = 0;
    for (int i = 0; i < rxCount && i < maxLog; i++)
    begin
      src = rxSrc[i];
      if (src >= 0)
      begin
        if (rxFlit[i][`TYPE_MSB:`TYPE_LSB] != nocArbPkg::HEAD)
          checkValue(src, rxFlit[i][12:10], "source field of output flit");
        if (seen[src] < txCount[src])
          checkValue(txFlit[src][seen[src]], rxFlit[i],
                     $sformatf("port %0d flit %0d", src, seen[src]));
        else
        begin
          errorCount++;
          $display("Output carried an extra flit from port %0d at %0t", src, $time);
        end
        seen[src]++;
      end
    end
    for (int p = 0; p < `NUM_PORTS; p++)
      checkValue(txCount[p], seen[p], $sformatf("flits received from port %0d", p));
  endtask

  // Answers outReq and logs the port whose input link is being acked.
  initial
  begin : receiver
    int delay;
    int src;
    outAck <= 1'b0;
    forever
    begin
      @(posedge clk);
      if (outReq && !outAck)
      begin
        src = -1;
        for (int p = 0; p < `NUM_PORTS; p++)
          if (inAck[p])
            src = p;
        if ($countones(inAck) != 1)
        begin
          errorCount++;
          $display("No single input link was acked for the output flit at %0t", $time);
        end
        if (rxCount < maxLog)
        begin
          rxFlit[rxCount] = outFlit;
          rxSrc[rxCount]  = src;
        end
        rxCount++;
        delay = $unsigned($random(seed)) % (ackDelayMax + 1);
        repeat (delay) @(posedge clk);
        outAck <= 1'b1;
        do
          @(posedge clk);
        while (outReq);
        outAck <= 1'b0;
      end
    end
  end

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic singleLocalPacket();
    checkValue(0, inAck, "inAck after reset");
    checkValue(0, outReq, "outReq after reset");
    clearStimulus();
    addPacket(0, 3, 3);
    runPorts();
    checkPortOrder();
  endtask

  task automatic idlePriority();
    clearStimulus();
    for (int p = 0; p < `NUM_PORTS; p++)
      addPacket(p, 2, 2);
    runPorts();
    checkValue(0, rxSrc[0], "source of first flit from idle");
    checkPortOrder();
  endtask

  // Two rounds, so a port that refills early waits behind the others.
  task automatic rotation();
    clearStimulus();
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      addFlit(p, headFlit(1));
      addFlit(p, headFlit(1));
    end
    runPorts();
    for (int i = 0; i < 2 * `NUM_PORTS; i++)
      checkValue(i % `NUM_PORTS, rxSrc[i], $sformatf("source of flit %0d in rotation", i));
  endtask

  // North header allows two flits per grant while East waits.
  task automatic budgetLimit();
    int eastLeft;
    int run;
    clearStimulus();
    addPacket(1, 2, 6);
    addPacket(2, 4, 4);
    runPorts();
    eastLeft = txCount[2];
    run = 0;
    for (int i = 0; i < rxCount && i < maxLog; i++)
    begin
      if (rxSrc[i] == 2)
      begin
        eastLeft--;
        run = 0;
      end
      else if (rxSrc[i] == 1)
      begin
        run++;
        if (eastLeft > 0)
          checkValue(1, (run <= 2), $sformatf("North run within budget at flit %0d", i));
      end
    end
    checkPortOrder();
  endtask

  task automatic backPressure();
    clearStimulus();
    ackDelayMax = 7;
    for (int p = 0; p < `NUM_PORTS; p++)
      addPacket(p, 3, 4);
    runPorts();
    checkPortOrder();
    ackDelayMax = 0;
  endtask

  initial
  begin
    seed        = 65;
    errorCount  = 0;
    checkCount  = 0;
    ackDelayMax = 0;
    rxCount     = 0;
    rst   <= 1'b1;
    inReq <= '0;
    for (int p = 0; p < `NUM_PORTS; p++)
      inFlit[p] <= '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    singleLocalPacket();
    idlePriority();
    rotation();
    budgetLimit();
    backPressure();
    $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* nocArb.f */
+incdir+design
design/nocArbPkg.sv
design/portTimer.sv
design/flitIngress.sv
design/grantArbiter.sv
design/flitForward.sv
design/nocArbTop.sv
tests/nocArb_checker.sv
tests/nocArbTb.sv

/* Bender.yml */
package:
  name: nocArb

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/nocArbPkg.sv
      - design/portTimer.sv
      - design/flitIngress.sv
      - design/grantArbiter.sv
      - design/flitForward.sv
      - design/nocArbTop.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/nocArb_checker.sv
      - tests/nocArbTb.sv
